// File: Bender.yml
package:
  name: genesis_bus

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mbus_pkg.sv
      - logic/zbus_pkg.sv
      - logic/sync_ram.sv
      - logic/mbus_arbiter.sv
      - logic/zbus_arbiter.sv
      - logic/genesis_bus.sv
  - target: test
    include_dirs:
      - logic
      - tests
    files:
      - tests/genesis_bus_tb.sv

// File: logic/bus_config.svh
// Bus map and sizing
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Address widths
// Main bus is word addressed, the Z80 bus byte addressed
`define MBUS_AW 23
`define ZBUS_AW 15

// Memory depths
// 32K words of 68K work RAM, 8K bytes of Z80 RAM
`define RAM68K_DEPTH_LOG2 15
`define ZRAM_DEPTH_LOG2 13

// Open bus value after reset (68000 NOP)
`define OPEN_BUS_RESET 16'h4E71

// Region bases on the top byte of the 68K byte address
`define ZWIN_BASE 8'hA0
`define CTRL_BASE 12'hA11
`define RAM68K_BASE 8'hE0

// Control register select, byte address bits 11:8
`define CTRL_BUSREQ 4'h1
`define CTRL_RESET 4'h2

// Z80 bank register page, Z80 address bits 14:8
`define ZBANK_PAGE 7'h60

`endif

// File: logic/genesis_bus.sv
// Console bus core top level
`timescale 1ns/1ps
`include "bus_config.svh"

module genesis_bus
	import mbus_pkg::*;
	import zbus_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,
	input  mbus_req_t   m68k_req,
	output mbus_rsp_t   m68k_rsp,
	input  dma_req_t    dma_req,
	output mbus_rsp_t   dma_rsp,
	input  z80_req_t    z80_req,
	output z80_rsp_t    z80_rsp,
	input  logic [23:0] rom_size,
	output rom_port_t   rom_port,
	output logic        rom_req,
	input  logic        rom_ack,
	input  mbus_word_t  rom_rdata,
	input  logic        z80_busak_n,
	output logic        z80_busreq,
	output logic        z80_reset_n
);

	logic [`RAM68K_DEPTH_LOG2-1:0] ram68k_addr;
	logic                          ram68k_we;
	logic [1:0]                    ram68k_be;
	mbus_word_t                    ram68k_wdata;
	mbus_word_t                    ram68k_rdata;
	logic [`ZRAM_DEPTH_LOG2-1:0]   zram_addr;
	logic                          zram_we;
	logic [7:0]                    zram_wdata;
	logic [7:0]                    zram_rdata;
	zbus_req_t                     zbus_req;
	zbus_rsp_t                     zbus_rsp;
	z80_rsp_t                      z80_bank_rsp;
	logic [8:0]                    bar;

	mbus_arbiter u_mbus (
		.MCLK(MCLK), .reset(reset),
		.m68k_req(m68k_req), .m68k_rsp(m68k_rsp),
		.dma_req(dma_req), .dma_rsp(dma_rsp),
		.z80_req(z80_req), .z80_rsp(z80_bank_rsp), .bar(bar),
		.ram68k_addr(ram68k_addr), .ram68k_we(ram68k_we), .ram68k_be(ram68k_be),
		.ram68k_wdata(ram68k_wdata), .ram68k_rdata(ram68k_rdata),
		.rom_size(rom_size), .rom_port(rom_port), .rom_req(rom_req),
		.rom_ack(rom_ack), .rom_rdata(rom_rdata),
		.zbus_req(zbus_req), .zbus_rsp(zbus_rsp),
		.z80_busak_n(z80_busak_n), .z80_busreq(z80_busreq), .z80_reset_n(z80_reset_n)
	);

	zbus_arbiter u_zbus (
		.MCLK(MCLK), .reset(reset),
		.zbus_req(zbus_req), .zbus_rsp(zbus_rsp),
		.z80_req(z80_req), .z80_rsp(z80_rsp), .z80_bank_rsp(z80_bank_rsp),
		.z80_busreq(z80_busreq), .z80_reset_n(z80_reset_n),
		.zram_addr(zram_addr), .zram_we(zram_we),
		.zram_wdata(zram_wdata), .zram_rdata(zram_rdata),
		.bar(bar)
	);

	// 68K work RAM, two lanes
	sync_ram #(.word_t(mbus_word_t), .DEPTH_LOG2(`RAM68K_DEPTH_LOG2)) ram68k (
		.MCLK(MCLK), .addr(ram68k_addr), .we(ram68k_we), .be(ram68k_be),
		.wdata(ram68k_wdata), .rdata(ram68k_rdata)
	);

	// Z80 RAM, single byte lane
	sync_ram #(.word_t(logic [7:0]), .DEPTH_LOG2(`ZRAM_DEPTH_LOG2)) zram (
		.MCLK(MCLK), .addr(zram_addr), .we(zram_we), .be(1'b1),
		.wdata(zram_wdata), .rdata(zram_rdata)
	);

endmodule

// File: logic/mbus_arbiter.sv
// Main bus arbiter
`timescale 1ns/1ps
`include "bus_config.svh"

module mbus_arbiter
	import mbus_pkg::*;
	import zbus_pkg::*;
(
	input  logic                          MCLK,
	input  logic                          reset,
	input  mbus_req_t                     m68k_req,
	output mbus_rsp_t                     m68k_rsp,
	input  dma_req_t                      dma_req,
	output mbus_rsp_t                     dma_rsp,
	input  z80_req_t                      z80_req,
	output z80_rsp_t                      z80_rsp,
	input  logic [8:0]                    bar,
	output logic [`RAM68K_DEPTH_LOG2-1:0] ram68k_addr,
	output logic                          ram68k_we,
	output logic [1:0]                    ram68k_be,
	output mbus_word_t                    ram68k_wdata,
	input  mbus_word_t                    ram68k_rdata,
	input  logic [23:0]                   rom_size,
	output rom_port_t                     rom_port,
	output logic                          rom_req,
	input  logic                          rom_ack,
	input  mbus_word_t                    rom_rdata,
	output zbus_req_t                     zbus_req,
	input  zbus_rsp_t                     zbus_rsp,
	input  logic                          z80_busak_n,
	output logic                          z80_busreq,
	output logic                          z80_reset_n
);

	typedef enum logic [2:0] {s_idle, s_decode, s_ram, s_rom, s_zbus, s_finish} state_t;

	state_t     state;
	master_t    msrc;
	mbus_req_t  lat;
	mbus_word_t data;
	mbus_word_t open_bus;
	mbus_word_t ctrl_word;
	logic       ack_q;
	logic       zbus_sel;
	logic [7:0] top_byte;
	logic       is_ram;
	logic       is_rom;
	logic       is_zwin;
	logic       is_ctrl;
	logic       ctrl_bit;
	logic       cur_sel;
	logic       z80_far;

	// Banked window, Z80 8000-FFFF
	assign z80_far = z80_req.sel && z80_req.addr[15];

	// ------------------------------
	// Region decode
	// ------------------------------
	assign top_byte = lat.addr[`MBUS_AW-1 -: 8];
	assign is_ram   = top_byte >= `RAM68K_BASE;
	assign is_zwin  = top_byte == `ZWIN_BASE;
	assign is_ctrl  = (lat.addr[`MBUS_AW-1 -: 12] == `CTRL_BASE) && (lat.addr[6:0] == '0);
	// Cartridge space ends where the Z80 window starts
	assign is_rom   = (top_byte < `ZWIN_BASE) && ({1'b0, lat.addr} < rom_size);

	always_comb begin
		case (lat.addr[10:7])
			`CTRL_BUSREQ: ctrl_bit = z80_busak_n;
			`CTRL_RESET:  ctrl_bit = z80_reset_n;
			default:      ctrl_bit = open_bus.hi[0];
		endcase
	end

	assign ctrl_word = '{hi: {open_bus.hi[7:1], ctrl_bit}, lo: open_bus.lo};

	always_comb begin
		case (msrc)
			m_68k:   cur_sel = m68k_req.sel;
			m_dma:   cur_sel = dma_req.sel;
			m_z80:   cur_sel = z80_far;
			default: cur_sel = 1'b0;
		endcase
	end

	// ------------------------------
	// Target ports
	// ------------------------------
	assign ram68k_addr  = lat.addr[`RAM68K_DEPTH_LOG2-1:0];
	assign ram68k_we    = (state == s_decode) && is_ram && !lat.rnw;
	assign ram68k_be    = lat.be;
	assign ram68k_wdata = lat.wdata;

	assign rom_port = '{addr: {1'b0, lat.addr}, be: lat.be, we: 1'b0, wdata: lat.wdata};

	// Hi lane sits at the even Z80 byte address
	assign zbus_req = '{sel: zbus_sel, rnw: lat.rnw,
		addr: {lat.addr[`ZBUS_AW-2:0], ~lat.be[1]},
		wdata: lat.be[1] ? lat.wdata.hi : lat.wdata.lo};

	assign m68k_rsp = '{ack: ack_q && (msrc == m_68k), rdata: data};
	assign dma_rsp  = '{ack: ack_q && (msrc == m_dma), rdata: data};
	assign z80_rsp  = '{ack: ack_q && (msrc == m_z80), rdata: lat.be[1] ? data.hi : data.lo};

	// ------------------------------
	// Arbitration FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= s_idle;
			msrc        <= m_none;
			ack_q       <= 1'b0;
			zbus_sel    <= 1'b0;
			rom_req     <= 1'b0;
			open_bus    <= `OPEN_BUS_RESET;
			z80_busreq  <= 1'b0;
			z80_reset_n <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					// Fixed priority, 68K over DMA over Z80
					if (m68k_req.sel) begin
						msrc  <= m_68k;
						lat   <= m68k_req;
						state <= s_decode;
					end else if (dma_req.sel) begin
						msrc  <= m_dma;
						lat   <= '{sel: 1'b1, rnw: 1'b1, be: 2'b11, addr: dma_req.addr, wdata: '0};
						state <= s_decode;
					end else if (z80_far) begin
						msrc  <= m_z80;
						lat   <= '{sel: 1'b1, rnw: z80_req.rnw,
							be: z80_req.addr[0] ? 2'b01 : 2'b10,
							addr: {bar, z80_req.addr[14:1]},
							wdata: '{hi: z80_req.wdata, lo: z80_req.wdata}};
						state <= s_decode;
					end
				end
				s_decode: begin
					data <= open_bus;
					if (is_ram) begin
						state <= s_ram;
					end else if (is_rom && lat.rnw) begin
						rom_req <= ~rom_req;
						state   <= s_rom;
					end else if (is_zwin) begin
						zbus_sel <= 1'b1;
						state    <= s_zbus;
					end else if (is_ctrl) begin
						data <= ctrl_word;
						if (!lat.rnw && lat.be[1]) begin
							if (lat.addr[10:7] == `CTRL_BUSREQ) z80_busreq <= lat.wdata.hi[0];
							if (lat.addr[10:7] == `CTRL_RESET) z80_reset_n <= lat.wdata.hi[0];
						end
						state <= s_finish;
					end else begin
						// Open bus, and ROM writes are dropped here
						state <= s_finish;
					end
				end
				s_ram: begin
					data <= ram68k_rdata;
					if (msrc == m_68k && lat.rnw) open_bus <= ram68k_rdata;
					state <= s_finish;
				end
				s_rom: begin
					if (rom_req == rom_ack) begin
						data <= rom_rdata;
						if (msrc == m_68k) open_bus <= rom_rdata;
						state <= s_finish;
					end
				end
				s_zbus: begin
					if (zbus_rsp.ack) begin
						zbus_sel <= 1'b0;
						data     <= '{hi: zbus_rsp.rdata, lo: zbus_rsp.rdata};
						state    <= s_finish;
					end
				end
				s_finish: begin
					// Hold ack until the master lets go
					if (!ack_q) begin
						ack_q <= 1'b1;
					end else if (!cur_sel) begin
						ack_q <= 1'b0;
						msrc  <= m_none;
						state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	a_one_ack: assert property (@(posedge MCLK) disable iff (reset)
		$onehot0({m68k_rsp.ack, dma_rsp.ack, z80_rsp.ack}));
	a_rom_toggle: assert property (@(posedge MCLK) disable iff (reset)
		$changed(rom_req) |-> state == s_rom);
	a_ack_68k: assert property (@(posedge MCLK) disable iff (reset)
		m68k_rsp.ack && !m68k_req.sel |-> $past(m68k_req.sel));
	a_ack_dma: assert property (@(posedge MCLK) disable iff (reset)
		dma_rsp.ack && !dma_req.sel |-> $past(dma_req.sel));
	a_ack_z80: assert property (@(posedge MCLK) disable iff (reset)
		z80_rsp.ack && !z80_far |-> $past(z80_far));

endmodule

// File: logic/mbus_pkg.sv
// Main bus types
`include "bus_config.svh"

package mbus_pkg;

	// One bus word as two byte lanes
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} mbus_word_t;

	// Read/write master request, held until ack
	typedef struct packed {
		logic                sel;
		logic                rnw;
		logic [1:0]          be;
		logic [`MBUS_AW-1:0] addr;
		mbus_word_t          wdata;
	} mbus_req_t;

	typedef struct packed {
		logic       ack;
		mbus_word_t rdata;
	} mbus_rsp_t;

	// DMA only reads full words
	typedef struct packed {
		logic                sel;
		logic [`MBUS_AW-1:0] addr;
	} dma_req_t;

	typedef enum logic [1:0] {m_none, m_68k, m_dma, m_z80} master_t;

	// Cartridge side of the ROM port
	typedef struct packed {
		logic [23:0] addr;
		logic [1:0]  be;
		logic        we;
		mbus_word_t  wdata;
	} rom_port_t;

endpackage

// File: logic/sync_ram.sv
// Byte-lane synchronous RAM
`timescale 1ns/1ps

module sync_ram #(
	parameter type word_t = logic [7:0],
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  MCLK,
	input  logic [DEPTH_LOG2-1:0] addr,
	input  logic                  we,
	input  logic [$bits(word_t)/8-1:0] be,
	input  word_t                 wdata,
	output word_t                 rdata
);

	localparam int WIDTH = $bits(word_t);
	localparam int LANES = WIDTH / 8;

	logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
	logic [WIDTH-1:0] wbits;

	assign wbits = wdata;

	// Lane writes, registered read
	always_ff @(posedge MCLK) begin
		if (we) begin
			for (int i = 0; i < LANES; i++) begin
				if (be[i]) begin
					mem[addr][i*8 +: 8] <= wbits[i*8 +: 8];
				end
			end
		end
		rdata <= word_t'(mem[addr]);
	end

	// Payload must split evenly into byte lanes
	a_lane_width: assert property (@(posedge MCLK) ($bits(word_t) % 8) == 0);

endmodule

// File: logic/zbus_arbiter.sv
// Z80 bus arbiter
`timescale 1ns/1ps
`include "bus_config.svh"

module zbus_arbiter
	import zbus_pkg::*;
(
	input  logic                        MCLK,
	input  logic                        reset,
	input  zbus_req_t                   zbus_req,
	output zbus_rsp_t                   zbus_rsp,
	input  z80_req_t                    z80_req,
	output z80_rsp_t                    z80_rsp,
	input  z80_rsp_t                    z80_bank_rsp,
	input  logic                        z80_busreq,
	input  logic                        z80_reset_n,
	output logic [`ZRAM_DEPTH_LOG2-1:0] zram_addr,
	output logic                        zram_we,
	output logic [7:0]                  zram_wdata,
	input  logic [7:0]                  zram_rdata,
	output logic [8:0]                  bar
);

	typedef enum logic [1:0] {z_idle, z_access, z_finish} zstate_t;

	zstate_t             zstate;
	logic                from_mbus;
	logic [`ZBUS_AW-1:0] za;
	logic [7:0]          zdo;
	logic                zwr;
	logic [7:0]          zdi;
	logic                bus_free;
	logic                z80_local;
	logic                mbus_ack;
	logic [7:0]          mbus_rdata;
	logic                local_ack;
	logic [7:0]          local_rdata;

	// 68K owns the Z80 bus only with the Z80 held off and out of reset
	assign bus_free  = z80_busreq && z80_reset_n;
	assign z80_local = z80_req.sel && !z80_req.addr[15];

	// ZRAM below 4000, mirrored; FM area and the rest read as FF
	assign zram_addr  = za[`ZRAM_DEPTH_LOG2-1:0];
	assign zram_wdata = zdo;
	assign zram_we    = zwr && !za[`ZBUS_AW-1];
	assign zdi        = za[`ZBUS_AW-1] ? 8'hFF : zram_rdata;

	assign zbus_rsp = '{ack: mbus_ack, rdata: mbus_rdata};

	// Local and banked answers never overlap
	assign z80_rsp = '{ack: local_ack || z80_bank_rsp.ack,
		rdata: local_ack ? local_rdata : z80_bank_rsp.rdata};

	// ------------------------------
	// Access FSM
	// ------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			zstate    <= z_idle;
			zwr       <= 1'b0;
			mbus_ack  <= 1'b0;
			local_ack <= 1'b0;
			bar       <= '0;
		end else begin
			zwr <= 1'b0;
			if (!zbus_req.sel) mbus_ack <= 1'b0;
			if (!z80_local) local_ack <= 1'b0;

			// Bank register shifts in one bit per write
			if (zwr && za[`ZBUS_AW-1 -: 7] == `ZBANK_PAGE) bar <= {zdo[0], bar[8:1]};

			case (zstate)
				z_idle: begin
					if (zbus_req.sel && !mbus_ack) begin
						za        <= zbus_req.addr;
						zdo       <= zbus_req.wdata;
						zwr       <= !zbus_req.rnw && bus_free;
						from_mbus <= 1'b1;
						zstate    <= z_access;
					end else if (z80_local && !local_ack) begin
						za        <= z80_req.addr[`ZBUS_AW-1:0];
						zdo       <= z80_req.wdata;
						zwr       <= !z80_req.rnw;
						from_mbus <= 1'b0;
						zstate    <= z_access;
					end
				end
				z_access: zstate <= z_finish;
				z_finish: begin
					if (from_mbus) begin
						mbus_rdata <= bus_free ? zdi : 8'hFF;
						mbus_ack   <= 1'b1;
					end else begin
						local_rdata <= zdi;
						local_ack   <= 1'b1;
					end
					zstate <= z_idle;
				end
				default: zstate <= z_idle;
			endcase
		end
	end

	a_zram_owner: assert property (@(posedge MCLK) disable iff (reset)
		zram_we && from_mbus |-> bus_free);

endmodule

// File: logic/zbus_pkg.sv
// Z80 bus types
`include "bus_config.svh"

package zbus_pkg;

	// Request as issued by the Z80 core
	typedef struct packed {
		logic        sel;
		logic        rnw;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} z80_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] rdata;
	} z80_rsp_t;

	// Main bus access into the Z80 window
	typedef struct packed {
		logic                sel;
		logic                rnw;
		logic [`ZBUS_AW-1:0] addr;
		logic [7:0]          wdata;
	} zbus_req_t;

	// Same layout as the Z80 response
	typedef z80_rsp_t zbus_rsp_t;

endpackage

// File: sources.f
+incdir+logic
+incdir+tests
logic/mbus_pkg.sv
logic/zbus_pkg.sv
logic/sync_ram.sv
logic/mbus_arbiter.sv
logic/zbus_arbiter.sv
logic/genesis_bus.sv
tests/genesis_bus_tb.sv

// File: tests/bus_ref_model.svh
// Bus target reference model
`ifndef BUS_REF_MODEL_SVH
`define BUS_REF_MODEL_SVH

// Cartridge size in words, driven onto rom_size
localparam logic [23:0] MODEL_ROM_SIZE = 24'h040000;

logic [15:0] model_ram [2**`RAM68K_DEPTH_LOG2];
logic [7:0]  model_zram [2**`ZRAM_DEPTH_LOG2];
logic [8:0]  model_bar;
logic        model_busreq;
logic        model_reset_n;
logic [15:0] model_open;

function automatic void model_init();
	model_bar     = '0;
	model_busreq  = 1'b0;
	model_reset_n = 1'b0;
	model_open    = `OPEN_BUS_RESET;
endfunction

// Cartridge contents as served by the ROM responder
function automatic logic [15:0] rom_pattern(input logic [22:0] wa);
	return wa[15:0] ^ 16'hA5C3;
endfunction

// One byte access on the Z80 bus
function automatic logic [7:0] zbus_model(input logic [14:0] za, input logic rnw,
		input logic [7:0] wd, input logic from_mbus);
	logic free;
	free = model_busreq && model_reset_n;
	if (from_mbus && !free) return 8'hFF;
	if (!rnw) begin
		if (!za[14]) begin
			model_zram[za[12:0]] = wd;
		end else if (za[14:8] == `ZBANK_PAGE) begin
			model_bar = {wd[0], model_bar[8:1]};
		end
		return 8'hFF;
	end
	return za[14] ? 8'hFF : model_zram[za[12:0]];
endfunction

// One word access on the main bus, returns the read data
function automatic logic [15:0] main_model(input logic [22:0] wa, input logic rnw,
		input logic [1:0] be, input logic [15:0] wd, input logic from_68k);
	logic [7:0]  top;
	logic [7:0]  zb;
	logic [15:0] rd;
	top = wa[22:15];
	rd  = model_open;
	if (top >= `RAM68K_BASE) begin
		if (!rnw && be[1]) model_ram[wa[14:0]][15:8] = wd[15:8];
		if (!rnw && be[0]) model_ram[wa[14:0]][7:0] = wd[7:0];
		rd = model_ram[wa[14:0]];
		if (rnw && from_68k) model_open = rd;
	end else if (top < `ZWIN_BASE && {1'b0, wa} < MODEL_ROM_SIZE) begin
		if (rnw) begin
			rd = rom_pattern(wa);
			if (from_68k) model_open = rd;
		end
	end else if (top == `ZWIN_BASE) begin
		// Even byte is the hi lane
		zb = zbus_model({wa[13:0], ~be[1]}, rnw, be[1] ? wd[15:8] : wd[7:0], 1'b1);
		rd = {zb, zb};
	end else if (wa[22:11] == `CTRL_BASE && wa[6:0] == 7'd0) begin
		// The testbench answers busreq with busak_n as its inverse
		if (wa[10:7] == `CTRL_BUSREQ) rd[8] = !model_busreq;
		if (wa[10:7] == `CTRL_RESET) rd[8] = model_reset_n;
		if (!rnw && be[1] && wa[10:7] == `CTRL_BUSREQ) model_busreq = wd[8];
		if (!rnw && be[1] && wa[10:7] == `CTRL_RESET) model_reset_n = wd[8];
	end
	return rd;
endfunction

// Z80 access, local or through the bank window
function automatic logic [7:0] z80_model(input logic [15:0] za, input logic rnw,
		input logic [7:0] wd);
	logic [1:0]  be;
	logic [15:0] rd;
	if (!za[15]) return zbus_model(za[14:0], rnw, wd, 1'b0);
	be = za[0] ? 2'b01 : 2'b10;
	rd = main_model({model_bar, za[14:1]}, rnw, be, {wd, wd}, 1'b0);
	return za[0] ? rd[7:0] : rd[15:8];
endfunction

`endif

// File: tests/genesis_bus_tb.sv
// Bus core testbench
`timescale 1ns/1ps
`include "bus_config.svh"

module genesis_bus_tb
	import mbus_pkg::*;
	import zbus_pkg::*;
();

	localparam int N_ZWIN      = 150;
	localparam int N_RAM       = 200;
	localparam int N_ROM       = 80;
	localparam int N_BANK_SETS = 6;
	localparam int N_BANK_ACC  = 12;
	localparam int N_CONC      = 60;
	localparam int NUM_TRANS   = 6 + 64 + N_ZWIN + 128 + N_RAM + 2 * N_ROM
		+ N_BANK_SETS * (9 + N_BANK_ACC) + 1 + 9 + 3 * N_CONC + 1;
	localparam int TIMEOUT_NS  = (NUM_TRANS * 40 + 10) * 100;

	logic        MCLK;
	logic        reset;
	mbus_req_t   m68k_req;
	mbus_rsp_t   m68k_rsp;
	dma_req_t    dma_req;
	mbus_rsp_t   dma_rsp;
	z80_req_t    z80_req;
	z80_rsp_t    z80_rsp;
	logic [23:0] rom_size;
	rom_port_t   rom_port;
	logic        rom_req;
	logic        rom_ack;
	mbus_word_t  rom_rdata;
	logic        z80_busak_n;
	logic        z80_busreq;
	logic        z80_reset_n;
	int          errors;

	`include "bus_ref_model.svh"

	genesis_bus UUT (
		.MCLK(MCLK), .reset(reset),
		.m68k_req(m68k_req), .m68k_rsp(m68k_rsp),
		.dma_req(dma_req), .dma_rsp(dma_rsp),
		.z80_req(z80_req), .z80_rsp(z80_rsp),
		.rom_size(rom_size), .rom_port(rom_port), .rom_req(rom_req),
		.rom_ack(rom_ack), .rom_rdata(rom_rdata),
		.z80_busak_n(z80_busak_n), .z80_busreq(z80_busreq), .z80_reset_n(z80_reset_n)
	);

	initial begin
		MCLK = 1'b0;
		forever #50 MCLK = ~MCLK;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "Value mismatch");
		end
	endtask

	function automatic logic [22:0] word_of(input logic [23:0] byte_addr);
		return byte_addr[23:1];
	endfunction

	task automatic m68k_access(input logic rnw, input logic [22:0] wa, input logic [1:0] be,
			input logic [15:0] wd);
		logic [15:0] exp;
		exp = main_model(wa, rnw, be, wd, 1'b1);
		@(negedge MCLK);
		m68k_req = '{sel: 1'b1, rnw: rnw, be: be, addr: wa, wdata: wd};
		@(negedge MCLK);
		while (!m68k_rsp.ack) @(negedge MCLK);
		if (rnw) check_value(m68k_rsp.rdata, exp, $sformatf("68K read at word %h", wa));
		m68k_req.sel = 1'b0;
	endtask

	task automatic dma_read(input logic [22:0] wa);
		logic [15:0] exp;
		exp = main_model(wa, 1'b1, 2'b11, 16'h0000, 1'b0);
		@(negedge MCLK);
		dma_req = '{sel: 1'b1, addr: wa};
		@(negedge MCLK);
		while (!dma_rsp.ack) @(negedge MCLK);
		check_value(dma_rsp.rdata, exp, $sformatf("DMA read at word %h", wa));
		dma_req.sel = 1'b0;
	endtask

	task automatic z80_access(input logic rnw, input logic [15:0] za, input logic [7:0] wd);
		logic [7:0] exp;
		exp = z80_model(za, rnw, wd);
		@(negedge MCLK);
		z80_req = '{sel: 1'b1, rnw: rnw, addr: za, wdata: wd};
		@(negedge MCLK);
		while (!z80_rsp.ack) @(negedge MCLK);
		if (rnw) check_value({8'h00, z80_rsp.rdata}, {8'h00, exp}, $sformatf("Z80 read at %h", za));
		z80_req.sel = 1'b0;
	endtask

	// Bank bits go in LSB first
	task automatic load_bank(input logic [8:0] bank);
		for (int i = 0; i < 9; i++) z80_access(1'b0, 16'h6000, {7'd0, bank[i]});
	endtask

	// ------------------------------
	// Cartridge and Z80 side
	// ------------------------------
	initial begin
		forever begin
			@(negedge MCLK);
			if (rom_req != rom_ack) begin
				check_value({15'd0, rom_port.we}, 16'd0, "ROM port write strobe on a read");
				repeat ($urandom % 6) @(negedge MCLK);
				rom_rdata = rom_pattern(rom_port.addr[22:0]);
				rom_ack   = rom_req;
			end
		end
	end

	// Z80 grants its bus one cycle after the request
	always @(negedge MCLK) z80_busak_n = ~z80_busreq;

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired, the bus hung before all transactions finished");
		$display(">>> FAIL");
		$fatal(1, "Timeout");
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		int unsigned seed;
		int          pick;
		logic [8:0]  bank;
		logic [22:0] wa;
		logic [15:0] za;
		reset       = 1'b1;
		m68k_req    = '0;
		dma_req     = '0;
		z80_req     = '0;
		rom_size    = MODEL_ROM_SIZE;
		rom_ack     = 1'b0;
		rom_rdata   = '0;
		z80_busak_n = 1'b1;
		errors      = 0;
		seed        = 32'h4743_8e1d;
		void'($urandom(seed));
		model_init();
		repeat (5) @(negedge MCLK);
		reset = 1'b0;

		check_value({15'd0, z80_busreq}, 16'd0, "z80_busreq after reset");
		check_value({15'd0, z80_reset_n}, 16'd0, "z80_reset_n after reset");
		check_value({15'd0, rom_req}, 16'd0, "rom_req after reset");
		check_value({15'd0, m68k_rsp.ack | dma_rsp.ack | z80_rsp.ack}, 16'd0, "ack after reset");

		// Control registers from reset
		m68k_access(1'b1, word_of(24'hA11100), 2'b11, 16'h0000);
		m68k_access(1'b1, word_of(24'hA11200), 2'b11, 16'h0000);
		m68k_access(1'b0, word_of(24'hA11100), 2'b11, 16'h0100);
		m68k_access(1'b0, word_of(24'hA11200), 2'b11, 16'h0100);
		check_value({15'd0, z80_busreq}, 16'd1, "z80_busreq after write");
		check_value({15'd0, z80_reset_n}, 16'd1, "z80_reset_n after write");
		m68k_access(1'b1, word_of(24'hA11100), 2'b11, 16'h0000);
		m68k_access(1'b1, word_of(24'hA11200), 2'b11, 16'h0000);

		for (int i = 0; i < 64; i++) z80_access(1'b0, i, $urandom);

		// Z80 window with the bus owner changing underneath
		for (int i = 0; i < N_ZWIN; i++) begin
			pick = $urandom % 8;
			if (pick == 0) begin
				m68k_access(1'b0, word_of(($urandom % 2) ? 24'hA11100 : 24'hA11200), 2'b11,
					{7'd0, ($urandom % 4) != 0, 8'h00});
			end else if (pick == 1) begin
				m68k_access(1'b1, word_of(($urandom % 2) ? 24'hA11100 : 24'hA11200), 2'b11, 0);
			end else if (pick < 5) begin
				m68k_access($urandom % 2, word_of(24'hA00000 | ($urandom & 24'h3E)),
					($urandom % 3) + 1, $urandom);
			end else begin
				z80_access($urandom % 2, $urandom & 16'h203F, $urandom);
			end
		end

		// Work RAM, mirrored every 64 KB
		for (int i = 0; i < 128; i++) begin
			m68k_access(1'b0, 23'h700000 | ((i / 64) << 14) | (i % 64), 2'b11, $urandom);
		end
		for (int i = 0; i < N_RAM; i++) begin
			m68k_access($urandom % 2, 23'h700000 | ($urandom & 23'h0FC03F), $urandom % 4, $urandom);
		end

		// Cartridge, some of it past rom_size
		for (int i = 0; i < N_ROM; i++) begin
			wa = $urandom % 23'h60000;
			if ($urandom % 4 == 0) m68k_access(1'b0, wa, 2'b11, $urandom);
			m68k_access(1'b1, wa, 2'b11, 16'h0000);
		end

		// Banked window into RAM or cartridge
		for (int s = 0; s < N_BANK_SETS; s++) begin
			bank = ($urandom % 2) ? (9'h1C0 | ($urandom % 64)) : ($urandom % 24);
			load_bank(bank);
			for (int j = 0; j < N_BANK_ACC; j++) begin
				za = 16'h8000 | ($urandom & (bank[8] ? 16'h007F : 16'h7FFF));
				z80_access(($urandom % 4) != 0, za, $urandom);
			end
		end
		z80_access(1'b1, 16'h6000, 8'h00);

		// All three masters at once, on disjoint targets
		load_bank(9'h1C1);
		fork
			for (int i = 0; i < N_CONC; i++) begin
				repeat ($urandom % 4) @(negedge MCLK);
				m68k_access($urandom % 2, 23'h700000 | ($urandom & 23'h0F803F), $urandom % 4,
					$urandom);
			end
			for (int i = 0; i < N_CONC; i++) begin
				dma_read(($urandom % 2) ? ($urandom % 23'h40000)
					: (23'h704000 | ($urandom & 23'h0F803F)));
			end
			for (int i = 0; i < N_CONC; i++) begin
				if ($urandom % 2) z80_access($urandom % 2, $urandom & 16'h203F, $urandom);
				else z80_access(1'b1, 16'h8000 | ($urandom & 16'h007F), 8'h00);
			end
		join

		// Unmapped read shows the last 68K read
		m68k_access(1'b1, 23'h600000, 2'b11, 16'h0000);

		if (errors == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "Checks failed");
		end
	end

endmodule
